// File: dv/replay_patterns.txt
# R logb_valid data_hex loge_hex = decoder record | T loge_hex delay_cycles = live pulses
# M mode = out_ready mode, 0 fill check, 1 always, 2 random | E = end of patterns
M 1
# first beat needs nothing, second waits for a channel 0 completion
R 1 a001 0
R 1 a002 1
T 1 3
# data-less record only moves channel 1, next beat waits on it
R 0 0000 2
R 1 a003 0
T 2 5
R 1 a004 c
T 4 2
T 8 1
# random back-pressure from here
M 2
T 3 0
R 1 b001 1
R 0 0000 2
R 1 b002 0
R 1 b003 8
T f 4
R 1 b004 3
T 9 2
R 1 b005 6
T 6 1
# output held low until the lane is full, then released
M 0
R 1 c001 0
R 1 c002 0
R 1 c003 0
R 1 c004 0
R 1 c005 0
R 1 c006 0
R 1 c007 0
R 1 c008 0
R 1 c009 0
R 1 c00a 0
R 1 c00b 0
M 2
R 1 d001 5
T 5 6
E

// File: dv/tb_replay_channel.sv
// self-checking testbench for the replay lane
// reads stimulus from dv/replay_patterns.txt and runs from the project root
`timescale 1ns/100ps

module tb_replay_channel;
  import replay_pkg::*;

  // cumulative completions a beat depends on per channel
  typedef logic [LOGE_CNT-1:0][15:0] need_t;

  // records accepted before o_rec_ready must fall with the output stalled
  localparam int FILL_LEVEL  = REPLAY_FIFO_DEPTH + REPLAYER_PIPE_DEPTH;
  // cycles a releasable beat may sit before it counts as a stall
  localparam int STALL_LIMIT = 20;

  logic         clk;
  logic         rstn;
  logic         i_rec_valid;
  logic         i_rec_logb_valid;
  replay_data_t i_rec_logb_data;
  loge_vec_t    i_rec_loge;
  logic         o_rec_ready;
  loge_vec_t    i_rt_loge;
  logic         o_out_valid;
  replay_data_t o_out_data;
  logic         i_out_ready;

  // parsed pattern lines
  logic [7:0]   cmd_kind [$];
  int           cmd_a    [$];
  int           cmd_b    [$];
  int           cmd_c    [$];
  int           n_lines         = 0;
  logic         patterns_loaded = 1'b0;

  // reference model state
  replay_data_t exp_data_q [$];
  need_t        exp_need_q [$];
  int           cum_need   [LOGE_CNT];
  int           rt_sum     [LOGE_CNT];
  loge_vec_t    rt_loge_q  [$];
  int           rt_delay_q [$];

  int           ready_mode  = 1;
  logic         monitor_on  = 1'b0;
  logic         fill_active = 1'b0;
  int           fill_cnt    = 0;
  int           err_value   = 0;
  int           err_other   = 0;
  int           beats_seen  = 0;
  logic [31:0]  rnd         = 32'h9115_eca6;

  replay_channel_top replay_channel_top_i (
    .clk              (clk),
    .rstn             (rstn),
    .i_rec_valid      (i_rec_valid),
    .i_rec_logb_valid (i_rec_logb_valid),
    .i_rec_logb_data  (i_rec_logb_data),
    .i_rec_loge       (i_rec_loge),
    .o_rec_ready      (o_rec_ready),
    .i_rt_loge        (i_rt_loge),
    .o_out_valid      (o_out_valid),
    .o_out_data       (o_out_data),
    .i_out_ready      (i_out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // compare tasks and helpers
  ////////////////////////////////////////////////////////////
  task automatic check_data(input string sig, input replay_data_t exp, input replay_data_t act);
    if (exp !== act) begin
      err_value++;
      $display("FAILED at %0t: %s expected %h, got %h", $time, sig, exp, act);
    end
  endtask

  task automatic check_flag(input string sig, input logic exp, input logic act);
    if (exp !== act) begin
      err_value++;
      $display("FAILED at %0t: %s expected %b, got %b", $time, sig, exp, act);
    end
  endtask

  task automatic check_state(input string sig, input replay_state_e exp,
                             input replay_state_e act);
    if (exp !== act) begin
      err_value++;
      $display("FAILED at %0t: %s expected %s, got %s", $time, sig, exp.name(), act.name());
    end
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // true once live completions cover what the beat waits for
  function automatic logic need_met(input need_t need);
    int   ch;
    logic met;
    met = 1'b1;
    for (ch = 0; ch < LOGE_CNT; ch++) begin
      if (rt_sum[ch] < int'(need[ch])) met = 1'b0;
    end
    return met;
  endfunction

  task automatic check_reset_outputs();
    check_flag("o_out_valid", 1'b0, o_out_valid);
    check_flag("o_rec_ready", 1'b0, o_rec_ready);
    check_state("replay_fsm_i.state", RS_EMPTY, replay_channel_top_i.replay_fsm_i.state);
  endtask

  // reads one pattern line per pass and skips comment lines
  task automatic load_patterns();
    int         fd;
    int         code;
    int         a;
    int         b;
    int         c;
    logic [7:0] kind;
    logic       done;
    string      rest;
    fd = $fopen("dv/replay_patterns.txt", "r");
    if (fd == 0) begin
      err_other++;
      $display("ERROR: cannot open dv/replay_patterns.txt");
    end else begin
      done = 1'b0;
      while (!done) begin
        code = $fscanf(fd, " %c", kind);
        a = 0;
        b = 0;
        c = 0;
        if (code != 1) begin
          done = 1'b1;
        end else if (kind == "#") begin
          code = $fgets(rest, fd);
        end else begin
          case (kind)
            "R": code = $fscanf(fd, "%d %h %h", a, b, c);
            "T": code = $fscanf(fd, "%h %d", a, b);
            "M": code = $fscanf(fd, "%d", a);
            "E": done = 1'b1;
            default: begin
              err_other++;
              $display("ERROR: unknown pattern line kind %c", kind);
              done = 1'b1;
            end
          endcase
          n_lines++;
          cmd_kind.push_back(kind);
          cmd_a.push_back(a);
          cmd_b.push_back(b);
          cmd_c.push_back(c);
        end
      end
      $fclose(fd);
    end
    patterns_loaded = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////
  // record driver called 2 ns after a rising edge
  ////////////////////////////////////////////////////////////
  task automatic push_record(input logic lv, input replay_data_t d, input loge_vec_t e);
    logic  acc;
    need_t need;
    int    ch;
    i_rec_valid      = 1'b1;
    i_rec_logb_valid = lv;
    i_rec_logb_data  = d;
    i_rec_loge       = e;
    acc = 1'b0;
    while (!acc) begin
      // o_rec_ready is registered and stable from one edge to the next
      @(negedge clk);
      acc = o_rec_ready;
      if (fill_active) begin
        check_flag("o_rec_ready", fill_cnt < FILL_LEVEL, o_rec_ready);
        if (!o_rec_ready && fill_cnt >= FILL_LEVEL) begin
          // lane is full so release the output and let it drain
          fill_active = 1'b0;
          ready_mode  = 1;
        end
      end
      @(posedge clk);
      #2;
    end
    if (fill_active) fill_cnt++;
    i_rec_valid = 1'b0;
    // each beat waits for all flags up to and including its own
    for (ch = 0; ch < LOGE_CNT; ch++) begin
      cum_need[ch] += int'(e[ch]);
      need[ch] = 16'(cum_need[ch]);
    end
    if (lv) begin
      exp_data_q.push_back(d);
      exp_need_q.push_back(need);
    end
  endtask

  // mode 0 holds ready low for the fill check, 1 keeps it high and 2 draws it at random
  task automatic set_ready_mode(input int mode);
    if (fill_active) begin
      err_other++;
      $display("ERROR at %0t: o_rec_ready never fell during the fill check", $time);
      fill_active = 1'b0;
    end
    if (mode == 0) begin
      // fill level is only exact from an empty lane
      while (exp_data_q.size() != 0) @(posedge clk);
      repeat (4) @(posedge clk);
      #2;
      fill_cnt    = 0;
      fill_active = 1'b1;
    end
    ready_mode = mode;
  endtask

  ////////////////////////////////////////////////////////////
  // runtime pulses and output ready
  ////////////////////////////////////////////////////////////
  initial begin : runtime_drive
    loge_vec_t pulse;
    int        delay;
    forever begin
      while (rt_loge_q.size() == 0) @(posedge clk);
      pulse = rt_loge_q.pop_front();
      delay = rt_delay_q.pop_front();
      repeat (delay) @(posedge clk);
      @(posedge clk);
      #2;
      i_rt_loge = pulse;
      @(posedge clk);
      #2;
      i_rt_loge = '0;
    end
  end

  initial begin : out_ready_drive
    logic ready_next;
    forever begin
      @(posedge clk);
      // sample the mode at the edge and drive ready 2 ns later
      case (ready_mode)
        0: ready_next = 1'b0;
        1: ready_next = 1'b1;
        default: begin
          rnd        = xorshift(rnd);
          ready_next = rnd[0];
        end
      endcase
      #2;
      i_out_ready = ready_next;
    end
  end

  ////////////////////////////////////////////////////////////
  // output monitor sampling at the falling edge
  ////////////////////////////////////////////////////////////
  task automatic take_beat(input replay_data_t act);
    need_t need;
    int    ch;
    if (exp_data_q.size() == 0) begin
      err_other++;
      $display("ERROR at %0t: beat %h came out with no record waiting for it", $time, act);
    end else begin
      check_data("o_out_data", exp_data_q.pop_front(), act);
      need = exp_need_q.pop_front();
      for (ch = 0; ch < LOGE_CNT; ch++) begin
        if (rt_sum[ch] < int'(need[ch])) begin
          err_other++;
          $display("ERROR at %0t: beat %h left before channel %0d reached %0d completions",
                   $time, act, ch, int'(need[ch]));
        end
      end
      beats_seen++;
    end
  endtask

  initial begin : out_monitor
    logic         hold_pending;
    replay_data_t hold_data;
    int           stall_cnt;
    int           ch;
    hold_pending = 1'b0;
    hold_data    = '0;
    stall_cnt    = 0;
    forever begin
      @(negedge clk);
      if (monitor_on) begin
        // a stalled beat must still be there and unchanged
        if (hold_pending) begin
          check_flag("o_out_valid", 1'b1, o_out_valid);
          check_data("o_out_data", hold_data, o_out_data);
        end
        hold_pending = o_out_valid && !i_out_ready;
        hold_data    = o_out_data;
        if (o_out_valid && i_out_ready) begin
          take_beat(o_out_data);
          stall_cnt = 0;
        end else if (exp_data_q.size() != 0 && !o_out_valid && need_met(exp_need_q[0])) begin
          stall_cnt++;
          if (stall_cnt == STALL_LIMIT) begin
            err_other++;
            $display("ERROR at %0t: beat %h held back although every channel caught up",
                     $time, exp_data_q[0]);
          end
        end else begin
          stall_cnt = 0;
        end
        // pulses seen now are counted by the DUT at the coming edge
        for (ch = 0; ch < LOGE_CNT; ch++) begin
          rt_sum[ch] += int'(i_rt_loge[ch]);
        end
      end
    end
  end

  initial begin : watchdog
    wait (patterns_loaded);
    repeat (40 * n_lines + 200) @(posedge clk);
    $display("timeout: run did not finish, %0d expected beats never came out",
             exp_data_q.size());
    $display("TESTS FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial begin : main_seq
    int i;
    rstn             = 1'b0;
    i_rec_valid      = 1'b0;
    i_rec_logb_valid = 1'b0;
    i_rec_logb_data  = '0;
    i_rec_loge       = '0;
    i_rt_loge        = '0;
    i_out_ready      = 1'b0;
    for (i = 0; i < LOGE_CNT; i++) begin
      cum_need[i] = 0;
      rt_sum[i]   = 0;
    end
    load_patterns();
    // reset spans 8 rising edges
    repeat (7) begin
      @(negedge clk);
      check_reset_outputs();
    end
    @(posedge clk);
    #2;
    rstn = 1'b1;
    @(negedge clk);
    check_reset_outputs();
    // registered ready comes up one cycle later
    @(negedge clk);
    check_flag("o_rec_ready", 1'b1, o_rec_ready);
    @(posedge clk);
    #2;
    monitor_on = 1'b1;
    for (i = 0; i < cmd_kind.size(); i++) begin
      case (cmd_kind[i])
        "R": push_record(cmd_a[i] != 0, replay_data_t'(cmd_b[i]), loge_vec_t'(cmd_c[i]));
        "T": begin
          rt_loge_q.push_back(loge_vec_t'(cmd_a[i]));
          rt_delay_q.push_back(cmd_b[i]);
        end
        "M": set_ready_mode(cmd_a[i]);
        default: ;
      endcase
    end
    // drain and then idle cycles to catch stray beats
    while (exp_data_q.size() != 0 || rt_loge_q.size() != 0) @(posedge clk);
    repeat (10) @(posedge clk);
    $display("summary: %0d value mismatches, %0d other failures, %0d beats checked",
             err_value, err_other, beats_seen);
    if (err_value == 0 && err_other == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: filelist.f
src/replay_pkg.sv
src/replay_fifo.sv
src/replay_fsm.sv
src/replay_buf.sv
src/pkt_order_cnt.sv
src/replay_channel_top.sv
dv/tb_replay_channel.sv

// File: run_sim.sh
#!/bin/sh
# build and run the replay lane testbench with Verilator
# exit status is 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --top-module tb_replay_channel \
    -f filelist.f -o sim_tb; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
  echo "run passed"
  exit 0
fi

echo "run failed, see $LOG"
exit 1

// File: src/pkt_order_cnt.sv
// per-channel transaction counters enforcing the recorded happens-before order
// compares live completions against replayed ones plus the head record
`timescale 1ns/100ps

module pkt_order_cnt (
  input  logic                  clk,
  input  logic                  rstn,
  // live completion pulses, no back-pressure
  input  replay_pkg::loge_vec_t i_rt_loge,
  // flags of the record at the replayer head
  input  replay_pkg::loge_vec_t i_head_loge,
  // head record retired
  input  logic                  i_remove,
  output logic                  o_ok_to_replay
);
  import replay_pkg::*;

  // counters wrap, only the difference matters
  logic [PKT_CNT_WIDTH-1:0] rt_cnt   [LOGE_CNT];
  logic [PKT_CNT_WIDTH-1:0] rep_cnt  [LOGE_CNT];
  // replay count once the head is counted in
  logic [PKT_CNT_WIDTH-1:0] rep_next [LOGE_CNT];
  logic [LOGE_CNT-1:0]      sign_clear;

  ////////////////////////////////////////////////////////////
  // runtime counters, every cycle
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int ch = 0; ch < LOGE_CNT; ch++) begin
        rt_cnt[ch] <= '0;
      end
    end else begin
      for (int ch = 0; ch < LOGE_CNT; ch++) begin
        rt_cnt[ch] <= rt_cnt[ch] + PKT_CNT_WIDTH'(i_rt_loge[ch]);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // replay counters, only when the head retires
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int ch = 0; ch < LOGE_CNT; ch++) begin
        rep_cnt[ch] <= '0;
      end
    end else if (i_remove) begin
      for (int ch = 0; ch < LOGE_CNT; ch++) begin
        rep_cnt[ch] <= rep_next[ch];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // wraparound compare per channel
  ////////////////////////////////////////////////////////////
  for (genvar ch = 0; ch < LOGE_CNT; ch++) begin : g_cmp
    logic [PKT_CNT_WIDTH-1:0] diff;

    // head flags count as already needed, the beat depends on them
    assign rep_next[ch] = rep_cnt[ch] + PKT_CNT_WIDTH'(i_head_loge[ch]);
    // runtime minus needed, msb is the sign while within half the circle
    assign diff = rt_cnt[ch] - rep_next[ch];
    assign sign_clear[ch] = ~diff[PKT_CNT_WIDTH-1];
  end

  // every channel must have caught up
  assign o_ok_to_replay = &sign_clear;

endmodule

// File: src/replay_buf.sv
// two-entry record buffer of the replayer, head register plus skid register
// loads are steered by the replayer FSM
`timescale 1ns/100ps

module replay_buf (
  input  logic                     clk,
  input  logic                     rstn,
  // steering from the FSM
  input  logic                     i_load_out,
  input  logic                     i_take_skid,
  input  logic                     i_load_skid,
  // incoming record from the FIFO head
  input  logic                     i_logb_valid,
  input  replay_pkg::replay_data_t i_logb_data,
  input  replay_pkg::loge_vec_t    i_loge,
  // head record
  output logic                     o_head_logb_valid,
  output replay_pkg::replay_data_t o_head_logb_data,
  output replay_pkg::loge_vec_t    o_head_loge
);
  import replay_pkg::*;

  // skid entry, holds the second record while the head waits
  logic         skid_logb_valid;
  replay_data_t skid_logb_data;
  loge_vec_t    skid_loge;

  ////////////////////////////////////////////////////////////
  // skid register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      skid_logb_valid <= 1'b0;
      skid_logb_data  <= '0;
      skid_loge       <= '0;
    end else if (i_load_skid) begin
      skid_logb_valid <= i_logb_valid;
      skid_logb_data  <= i_logb_data;
      skid_loge       <= i_loge;
    end
  end

  ////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      o_head_logb_valid <= 1'b0;
      o_head_logb_data  <= '0;
      o_head_loge       <= '0;
    end else if (i_take_skid) begin
      // full to busy, skid moves up
      o_head_logb_valid <= skid_logb_valid;
      o_head_logb_data  <= skid_logb_data;
      o_head_loge       <= skid_loge;
    end else if (i_load_out) begin
      // load or flow from the input
      o_head_logb_valid <= i_logb_valid;
      o_head_logb_data  <= i_logb_data;
      o_head_loge       <= i_loge;
    end
  end

endmodule

// File: src/replay_channel_top.sv
// one replay lane: record FIFO, replayer FSM and buffer, order counters
// decoder records in, ordered data beats out
`timescale 1ns/100ps

module replay_channel_top (
  input  logic                     clk,
  input  logic                     rstn,
  // replay records from the log decoder
  input  logic                     i_rec_valid,
  input  logic                     i_rec_logb_valid,
  input  replay_pkg::replay_data_t i_rec_logb_data,
  input  replay_pkg::loge_vec_t    i_rec_loge,
  output logic                     o_rec_ready,
  // live completion pulses
  input  replay_pkg::loge_vec_t    i_rt_loge,
  // replayed beats
  output logic                     o_out_valid,
  output replay_pkg::replay_data_t o_out_data,
  input  logic                     i_out_ready
);
  import replay_pkg::*;

  // FIFO head
  logic         fifo_valid;
  logic         fifo_logb_valid;
  replay_data_t fifo_logb_data;
  loge_vec_t    fifo_loge;
  logic         fsm_in_ready;
  // buffer steering and head record
  logic         load_out;
  logic         take_skid;
  logic         load_skid;
  logic         head_logb_valid;
  loge_vec_t    head_loge;
  // ordering
  logic         remove;
  logic         ok_to_replay;

  replay_fifo #(
    .DEPTH(REPLAY_FIFO_DEPTH)
  ) replay_fifo_i (
    .clk             (clk),
    .rstn            (rstn),
    .i_wr_valid      (i_rec_valid),
    .i_wr_logb_valid (i_rec_logb_valid),
    .i_wr_logb_data  (i_rec_logb_data),
    .i_wr_loge       (i_rec_loge),
    .o_wr_ready      (o_rec_ready),
    .o_rd_valid      (fifo_valid),
    .o_rd_logb_valid (fifo_logb_valid),
    .o_rd_logb_data  (fifo_logb_data),
    .o_rd_loge       (fifo_loge),
    .i_rd_ready      (fsm_in_ready)
  );

  replay_fsm replay_fsm_i (
    .clk               (clk),
    .rstn              (rstn),
    .i_in_valid        (fifo_valid),
    .o_in_ready        (fsm_in_ready),
    .i_head_logb_valid (head_logb_valid),
    .i_ok_to_replay    (ok_to_replay),
    .i_out_ready       (i_out_ready),
    .o_out_valid       (o_out_valid),
    .o_load_out        (load_out),
    .o_take_skid       (take_skid),
    .o_load_skid       (load_skid),
    .o_remove          (remove)
  );

  // head data feeds the output port directly
  replay_buf replay_buf_i (
    .clk               (clk),
    .rstn              (rstn),
    .i_load_out        (load_out),
    .i_take_skid       (take_skid),
    .i_load_skid       (load_skid),
    .i_logb_valid      (fifo_logb_valid),
    .i_logb_data       (fifo_logb_data),
    .i_loge            (fifo_loge),
    .o_head_logb_valid (head_logb_valid),
    .o_head_logb_data  (o_out_data),
    .o_head_loge       (head_loge)
  );

  pkt_order_cnt pkt_order_cnt_i (
    .clk            (clk),
    .rstn           (rstn),
    .i_rt_loge      (i_rt_loge),
    .i_head_loge    (head_loge),
    .i_remove       (remove),
    .o_ok_to_replay (ok_to_replay)
  );

endmodule

// File: src/replay_fifo.sv
// show-ahead record FIFO between the log decoder and the replayer
// head record is visible on the read side without a pop
`timescale 1ns/100ps

module replay_fifo #(
  parameter int DEPTH = replay_pkg::REPLAY_FIFO_DEPTH
) (
  input  logic                     clk,
  input  logic                     rstn,
  // write side, from the decoder
  input  logic                     i_wr_valid,
  input  logic                     i_wr_logb_valid,
  input  replay_pkg::replay_data_t i_wr_logb_data,
  input  replay_pkg::loge_vec_t    i_wr_loge,
  output logic                     o_wr_ready,
  // read side, head record
  output logic                     o_rd_valid,
  output logic                     o_rd_logb_valid,
  output replay_pkg::replay_data_t o_rd_logb_data,
  output replay_pkg::loge_vec_t    o_rd_loge,
  input  logic                     i_rd_ready
);
  import replay_pkg::*;

  // record storage, one array per field
  logic         mem_logb_valid [DEPTH];
  replay_data_t mem_logb_data  [DEPTH];
  loge_vec_t    mem_loge       [DEPTH];

  logic [$clog2(DEPTH)-1:0]   wr_ptr;
  logic [$clog2(DEPTH)-1:0]   rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic [$clog2(DEPTH+1)-1:0] count_next;
  logic                       wr_en;
  logic                       rd_en;

  // o_wr_ready is low whenever full, so a write never lands on a full FIFO
  assign wr_en = i_wr_valid && o_wr_ready;
  assign rd_en = o_rd_valid && i_rd_ready;

  // occupancy after this edge
  always_comb begin
    count_next = count;
    if (wr_en && !rd_en) begin
      count_next = count + 1'b1;
    end else if (!wr_en && rd_en) begin
      count_next = count - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // pointers, count and registered not-full
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      o_wr_ready <= 1'b0;
    end else begin
      // wrap by compare, depth need not be a power of two
      if (wr_en) begin
        wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      count      <= count_next;
      o_wr_ready <= (int'(count_next) != DEPTH);
    end
  end

  // storage write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_logb_valid[wr_ptr] <= i_wr_logb_valid;
      mem_logb_data[wr_ptr]  <= i_wr_logb_data;
      mem_loge[wr_ptr]       <= i_wr_loge;
    end
  end

  // head record straight from storage
  assign o_rd_valid      = (count != '0);
  assign o_rd_logb_valid = mem_logb_valid[rd_ptr];
  assign o_rd_logb_data  = mem_logb_data[rd_ptr];
  assign o_rd_loge       = mem_loge[rd_ptr];

endmodule

// File: src/replay_fsm.sv
// replayer control: tracks buffer occupancy, steers the two-entry buffer
// and decides when the head beat may go out
`timescale 1ns/100ps

module replay_fsm (
  input  logic clk,
  input  logic rstn,
  // record input from the FIFO head
  input  logic i_in_valid,
  output logic o_in_ready,
  // head record and ordering status
  input  logic i_head_logb_valid,
  input  logic i_ok_to_replay,
  // output handshake
  input  logic i_out_ready,
  output logic o_out_valid,
  // buffer steering
  output logic o_load_out,
  output logic o_take_skid,
  output logic o_load_skid,
  // head retired this cycle
  output logic o_remove
);
  import replay_pkg::*;

  replay_state_e state;
  replay_state_e state_next;
  logic          insert;
  logic          remove_beat;
  logic          remove_empty_rec;

  assign insert = i_in_valid && o_in_ready;

  // data beat accepted downstream
  assign remove_beat = o_out_valid && i_out_ready;
  // record with no beat only moves the counters, one cycle fast path
  assign remove_empty_rec = (state != RS_EMPTY) && !i_head_logb_valid;
  assign o_remove = remove_beat || remove_empty_rec;

  ////////////////////////////////////////////////////////////
  // occupancy FSM
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_next = state;
    case (state)
      RS_EMPTY: begin
        // load
        if (insert) state_next = RS_BUSY;
      end
      RS_BUSY: begin
        // fill or unload, flow and idle stay
        if (insert && !o_remove) begin
          state_next = RS_FULL;
        end else if (!insert && o_remove) begin
          state_next = RS_EMPTY;
        end
      end
      RS_FULL: begin
        // flush skid into the output register
        if (!insert && o_remove) state_next = RS_BUSY;
      end
      default: state_next = RS_EMPTY;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state      <= RS_EMPTY;
      o_in_ready <= 1'b0;
    end else begin
      state      <= state_next;
      // registered ready, drops once both entries are taken
      o_in_ready <= (state_next != RS_FULL);
    end
  end

  // new record goes straight to the head on load or flow
  assign o_load_out  = insert && (state_next == RS_BUSY);
  assign o_take_skid = (state == RS_FULL) && (state_next == RS_BUSY);
  assign o_load_skid = (state == RS_BUSY) && (state_next == RS_FULL);

  // hold the beat until every channel has caught up
  assign o_out_valid = (state != RS_EMPTY) && i_head_logb_valid && i_ok_to_replay;

endmodule

// File: src/replay_pkg.sv
// shared widths, depths and types for the replay lane
// imported by every RTL block and by the testbench
package replay_pkg;

  ////////////////////////////////////////////////////////////
  // data path sizes
  ////////////////////////////////////////////////////////////

  // one replayed data beat
  localparam int DATA_WIDTH = 16;
  // tracked channels, one end-of-transaction flag each
  localparam int LOGE_CNT = 4;

  ////////////////////////////////////////////////////////////
  // buffering and counter sizing
  ////////////////////////////////////////////////////////////

  // default record FIFO depth
  localparam int REPLAY_FIFO_DEPTH = 8;
  // output register plus skid register in the replayer
  localparam int REPLAYER_PIPE_DEPTH = 2;
  // decoder merge tree and output queue slack upstream of this lane
  localparam int UPSTREAM_ALLOWANCE = 3;

  // worst-case distance between runtime and replay counts
  localparam int ON_THE_FLY_CNT =
    REPLAY_FIFO_DEPTH + REPLAYER_PIPE_DEPTH + UPSTREAM_ALLOWANCE;

  // twice the distance so both counts stay on one half of the circle,
  // which keeps the msb of the difference a valid sign
  localparam int PKT_CNT_WIDTH = $clog2(2 * ON_THE_FLY_CNT);

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  typedef logic [DATA_WIDTH-1:0] replay_data_t;
  typedef logic [LOGE_CNT-1:0]   loge_vec_t;

  // number of records held in the replayer buffer
  typedef enum logic [1:0] {
    RS_EMPTY = 2'd0,
    RS_BUSY  = 2'd1,
    RS_FULL  = 2'd2
  } replay_state_e;

endpackage
